// ==== verilog/board_pkg.sv ====
// stopwatch run-state type and key index constants.

`default_nettype none

package board_pkg;

    // what the stopwatch is doing right now.
    typedef enum logic [1:0] {
        st_stopped  = 2'd0,
        st_running  = 2'd1,
        st_clearing = 2'd2
    } run_state_t;

    // positions within the key vector, after inversion.
    localparam int key_run   = 0;  // start / stop.
    localparam int key_clear = 1;  // zero the count, stopped only.

endpackage

`default_nettype wire

// ==== verilog/seg_pkg.sv ====
// seven-segment pattern type and hex digit lookup table.

`default_nettype none

package seg_pkg;

    // abcdefgh order, h is the decimal point, 1 lights the segment.
    typedef logic [7:0] seg_t;

    // patterns for 0 through F, decimal point always dark.
    localparam seg_t seg_digits [16] = '{
        8'b1111_1100,  // 0.
        8'b0110_0000,  // 1.
        8'b1101_1010,  // 2.
        8'b1111_0010,  // 3.
        8'b0110_0110,  // 4.
        8'b1011_0110,  // 5.
        8'b1011_1110,  // 6.
        8'b1110_0000,  // 7.
        8'b1111_1110,  // 8.
        8'b1111_0110,  // 9.
        8'b1110_1110,  // A.
        8'b0011_1110,  // b.
        8'b1001_1100,  // C.
        8'b0111_1010,  // d.
        8'b1001_1110,  // E.
        8'b1000_1110   // F.
    };

endpackage

`default_nettype wire

// ==== verilog/tick_timer.sv ====
// free-running dividers for the count tick and the display refresh strobe.

`default_nettype none

module tick_timer
# (
    parameter tick_cycles    = 500000,
              refresh_cycles = 50000
)
(
    input  wire  clk,
    input  wire  rst,
    output logic tick,
    output logic refresh
);

    localparam int w_tick    = tick_cycles    > 1 ? $clog2(tick_cycles)    : 1;
    localparam int w_refresh = refresh_cycles > 1 ? $clog2(refresh_cycles) : 1;

    localparam logic [w_tick    - 1:0] tick_last    = w_tick'(tick_cycles - 1);
    localparam logic [w_refresh - 1:0] refresh_last = w_refresh'(refresh_cycles - 1);

    logic [w_tick    - 1:0] tick_cnt;
    logic [w_refresh - 1:0] refresh_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick     <= (tick_cnt == tick_last);  // one pulse per wrap.
            tick_cnt <= (tick_cnt == tick_last) ? '0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            refresh     <= 1'b0;
        end else begin
            refresh     <= (refresh_cnt == refresh_last);
            refresh_cnt <= (refresh_cnt == refresh_last) ? '0 : refresh_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bcd_counter.sv ====
// multi-digit bcd up counter with a four-phase handshaken clear.

`default_nettype none

module bcd_counter
# (
    parameter w_digit = 4
)
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       tick,
    input  wire                       count_en,
    input  wire                       clear_req,
    output logic [4 * w_digit - 1:0]  bcd,
    output logic                      clear_ack
);

    logic [4 * w_digit - 1:0] bcd_next;
    logic                     carry;

    // ripple the +1 up through the digits, 9 rolls to 0.
    always_comb begin
        carry    = 1'b1;
        bcd_next = bcd;
        for (int i = 0; i < w_digit; i++) begin
            if (carry) begin
                if (bcd[4 * i +: 4] == 4'd9) begin
                    bcd_next[4 * i +: 4] = 4'd0;
                end else begin
                    bcd_next[4 * i +: 4] = bcd[4 * i +: 4] + 4'd1;
                    carry                = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bcd       <= '0;
            clear_ack <= 1'b0;
        end else if (clear_req) begin
            bcd       <= '0;     // clear wins over a tick.
            clear_ack <= 1'b1;
        end else begin
            clear_ack <= 1'b0;   // req seen low, release ack.
            if (tick && count_en)
                bcd <= bcd_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stopwatch_fsm.sv ====
// key synchronizer, rising edge detect and run/stop/clear state machine.

`default_nettype none

module stopwatch_fsm
# (
    parameter w_key = 4
)
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [w_key - 1:0]      key,
    input  wire                     clear_ack,
    output board_pkg::run_state_t   state,
    output logic                    count_en,
    output logic                    clear_req
);

    logic [w_key - 1:0] key_meta;
    logic [w_key - 1:0] key_sync;
    logic [w_key - 1:0] key_prev;
    logic [w_key - 1:0] key_rise;

    // two flops against metastability, a third for the edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_rise = key_sync & ~ key_prev;
    assign count_en = (state == board_pkg::st_running);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= board_pkg::st_stopped;
            clear_req <= 1'b0;
        end else begin
            case (state)
                board_pkg::st_stopped:
                    if (key_rise[board_pkg::key_run]) begin
                        state <= board_pkg::st_running;
                    end else if (key_rise[board_pkg::key_clear]) begin
                        state     <= board_pkg::st_clearing;
                        clear_req <= 1'b1;  // hold until acked.
                    end
                board_pkg::st_running:
                    if (key_rise[board_pkg::key_run])
                        state <= board_pkg::st_stopped;
                board_pkg::st_clearing:
                    // drop req on ack, leave once ack has fallen too.
                    if (clear_ack)
                        clear_req <= 1'b0;
                    else if (!clear_req)
                        state <= board_pkg::st_stopped;
                default:
                    state <= board_pkg::st_stopped;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/seg_display.sv ====
// digit scan register and segment decoder for a multiplexed display.

`default_nettype none

module seg_display
# (
    parameter w_digit = 4
)
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       refresh,
    input  wire  [4 * w_digit - 1:0]  bcd,
    output seg_pkg::seg_t             abcdefgh,
    output logic [w_digit - 1:0]      digit
);

    localparam int w_idx = w_digit > 1 ? $clog2(w_digit) : 1;
    localparam logic [w_idx - 1:0] idx_last = w_idx'(w_digit - 1);

    logic [w_idx - 1:0] scan;
    logic [3:0]         nibble;

    assign nibble = bcd[4 * scan +: 4];

    // step to the next position on each refresh strobe.
    always_ff @(posedge clk) begin
        if (rst)
            scan <= '0;
        else if (refresh)
            scan <= (scan == idx_last) ? '0 : scan + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            digit <= w_digit'(1);  // rightmost digit first.
        else
            digit <= w_digit'(1) << scan;
    end

    // pattern follows the select in the same cycle.
    always_ff @(posedge clk)
        abcdefgh <= seg_pkg::seg_digits[nibble];

endmodule

`default_nettype wire

// ==== verilog/top.sv ====
// board-neutral stopwatch core: fsm, timer, bcd counter, display and leds.

`default_nettype none

module top
# (
    parameter clk_mhz        = 50,
              w_key          = 4,
              w_sw           = 8,
              w_led          = 8,
              w_digit        = 4,
              tick_cycles    = clk_mhz * 10000,
              refresh_cycles = clk_mhz * 1000
)
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [w_key - 1:0]      key,
    input  wire  [w_sw  - 1:0]      sw,      // switches not used yet.
    output logic [w_led - 1:0]      led,
    output seg_pkg::seg_t           abcdefgh,
    output logic [w_digit - 1:0]    digit
);

    board_pkg::run_state_t   state;
    logic                    count_en;
    logic                    clear_req;
    logic                    clear_ack;
    logic                    tick;
    logic                    refresh;
    logic [4 * w_digit - 1:0] bcd;

    always_comb begin
        led    = '0;
        led[0] = (state == board_pkg::st_running);
        led[1] = (state == board_pkg::st_clearing);
    end

    stopwatch_fsm # (.w_key (w_key)) i_fsm (
        .clk, .rst, .key, .clear_ack,
        .state, .count_en, .clear_req
    );

    tick_timer # (
        .tick_cycles    ( tick_cycles    ),
        .refresh_cycles ( refresh_cycles )
    ) i_timer (
        .clk, .rst, .tick, .refresh
    );

    bcd_counter # (.w_digit (w_digit)) i_counter (
        .clk, .rst, .tick, .count_en, .clear_req,
        .bcd, .clear_ack
    );

    seg_display # (.w_digit (w_digit)) i_display (
        .clk, .rst, .refresh, .bcd,
        .abcdefgh, .digit
    );

endmodule

`default_nettype wire

// ==== verilog/board_specific_top.sv ====
// board wrapper: active-low pin inversion, clock and reset pick, core instance.

`default_nettype none

module board_specific_top
# (
    parameter clk_mhz        = 50,
              w_key          = 4,
              w_sw           = 8,
              w_led          = 8,
              w_digit        = 4,
              tick_cycles    = clk_mhz * 10000,  // hundredths of a second.
              refresh_cycles = clk_mhz * 1000
)
(
    input  wire                 clkin_50,
    input  wire                 clkin_125,
    input  wire                 clkin_sma,
    input  wire                 clkout_sma,

    input  wire                 cpu_resetn,

    input  wire [w_key - 1:0]   user_pb,
    input  wire [w_sw  - 1:0]   user_dipsw,
    output wire [w_led - 1:0]   user_led,

    output wire                 seven_seg_a,
    output wire                 seven_seg_b,
    output wire                 seven_seg_c,
    output wire                 seven_seg_d,
    output wire                 seven_seg_e,
    output wire                 seven_seg_f,
    output wire                 seven_seg_g,
    output wire                 seven_seg_dp,
    output wire                 seven_seg_minus,

    output wire [w_digit    :1] seven_seg_sel,

    output wire                 speaker_out
);

    // only the 50 MHz oscillator clocks the design.
    wire clk = clkin_50;
    wire rst = ~ cpu_resetn;

    seg_pkg::seg_t        abcdefgh;
    wire [w_digit - 1:0] digit;

    assign seven_seg_minus = 1'b0;
    assign speaker_out     = 1'b0;  // no sound here.

    // common-anode display, segments and selects both pull low.
    assign { seven_seg_a, seven_seg_b, seven_seg_c, seven_seg_d,
             seven_seg_e, seven_seg_f, seven_seg_g, seven_seg_dp } = ~ abcdefgh;

    assign seven_seg_sel = ~ digit;

    top
    # (
        .clk_mhz        ( clk_mhz        ),
        .w_key          ( w_key          ),
        .w_sw           ( w_sw           ),
        .w_led          ( w_led          ),
        .w_digit        ( w_digit        ),
        .tick_cycles    ( tick_cycles    ),
        .refresh_cycles ( refresh_cycles )
    )
    i_top
    (
        .clk      (   clk        ),
        .rst      (   rst        ),
        .key      ( ~ user_pb    ),  // buttons read 0 when pressed.
        .sw       (   user_dipsw ),
        .led      (   user_led   ),
        .abcdefgh (   abcdefgh   ),
        .digit    (   digit      )
    );

endmodule

`default_nettype wire

// ==== tb/tb_board_specific_top.sv ====
// stopwatch board wrapper testbench with stimulus table, display decoder model and watchdog.

`default_nettype none

module tb_board_specific_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period     = 8;
    localparam int tick_cycles    = 8;
    localparam int refresh_cycles = 4;
    localparam int press_cycles   = 24;                      // whole press, hold plus release.
    localparam int scan_cycles    = 5 * refresh_cycles;      // one full rotation and a spare step.
    localparam int n_rows         = 15;

    localparam logic [1:0] act_wait  = 2'd0;
    localparam logic [1:0] act_run   = 2'd1;
    localparam logic [1:0] act_clear = 2'd2;

    typedef struct packed {
        logic [1:0] act;
        int         cycles;    // wait length, wait rows only.
        logic       chk;       // read the display after the row.
        logic       same;      // display must equal the previous reading.
        int         expected;
        int         tol;
        logic [7:0] led;
        logic       pulse;     // led[1] seen high during the press.
    } row_t;

    // press rows last press_cycles plus one, so the counts follow from the waits.
    row_t rows [n_rows] = '{
        '{act_wait,    4, 1'b1, 1'b0,   0, 0, 8'h00, 1'b0},  // state after reset.
        '{act_run,     0, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_wait,   80, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_run,     0, 1'b1, 1'b0,  13, 1, 8'h00, 1'b0},  // 105 cycles of running.
        '{act_wait,   40, 1'b1, 1'b1,   0, 0, 8'h00, 1'b0},  // frozen while stopped.
        '{act_clear,   0, 1'b1, 1'b0,   0, 0, 8'h00, 1'b1},
        '{act_run,     0, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_wait,   40, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_clear,   0, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},  // ignored while running.
        '{act_wait,   40, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_run,     0, 1'b1, 1'b0,  16, 1, 8'h00, 1'b0},  // 130 cycles of running.
        '{act_clear,   0, 1'b1, 1'b0,   0, 0, 8'h00, 1'b1},
        '{act_run,     0, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_wait,  784, 1'b0, 1'b0,   0, 0, 8'h01, 1'b0},
        '{act_run,     0, 1'b1, 1'b0, 101, 1, 8'h00, 1'b0}   // through 0099 into 0100.
    };

    logic       clk = 1'b0;
    logic       clkin_125;
    logic       clkin_sma;
    logic       clkout_sma;
    logic       cpu_resetn;
    logic [3:0] user_pb;
    logic [7:0] user_dipsw;
    wire  [7:0] user_led;
    wire        seg_a, seg_b, seg_c, seg_d, seg_e, seg_f, seg_g, seg_dp;
    wire        seven_seg_minus;
    wire  [4:1] seven_seg_sel;
    wire        speaker_out;

    board_specific_top # (
        .tick_cycles    ( tick_cycles    ),
        .refresh_cycles ( refresh_cycles )
    ) dut_i (
        .clkin_50        ( clk             ),
        .clkin_125       ( clkin_125       ),
        .clkin_sma       ( clkin_sma       ),
        .clkout_sma      ( clkout_sma      ),
        .cpu_resetn      ( cpu_resetn      ),
        .user_pb         ( user_pb         ),
        .user_dipsw      ( user_dipsw      ),
        .user_led        ( user_led        ),
        .seven_seg_a     ( seg_a           ),
        .seven_seg_b     ( seg_b           ),
        .seven_seg_c     ( seg_c           ),
        .seven_seg_d     ( seg_d           ),
        .seven_seg_e     ( seg_e           ),
        .seven_seg_f     ( seg_f           ),
        .seven_seg_g     ( seg_g           ),
        .seven_seg_dp    ( seg_dp          ),
        .seven_seg_minus ( seven_seg_minus ),
        .seven_seg_sel   ( seven_seg_sel   ),
        .speaker_out     ( speaker_out     )
    );

    always #(clk_period / 2) clk = ~ clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // decimal value as four bcd nibbles.
    function automatic logic [15:0] to_bcd(input int v);
        return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
    endfunction

    // press a key for a random hold, release, and watch led[1] throughout.
    task automatic press_key(input int k, output logic seen_clear);
        int hold;
        hold       = 1 + ($urandom % 4);
        seen_clear = 1'b0;
        @(posedge clk);
        user_pb[k] <= 1'b0;                 // active low on the board.
        for (int i = 1; i <= press_cycles; i++) begin
            @(negedge clk);
            if (user_led[1])
                seen_clear = 1'b1;
            @(posedge clk);
            if (i == hold)
                user_pb[k] <= 1'b1;
        end
    endtask

    // undo pin polarity, look each pattern up and rebuild the value.
    task automatic read_display(output int value);
        logic [7:0] pat;
        logic [3:0] sel;
        logic [3:0] seen;
        int         idx;
        int         d [4];
        seen = '0;
        d    = '{0, 0, 0, 0};
        for (int c = 0; c < scan_cycles; c++) begin
            @(negedge clk);
            pat = ~ {seg_a, seg_b, seg_c, seg_d, seg_e, seg_f, seg_g, seg_dp};
            sel = ~ seven_seg_sel;
            assert ($countones(sel) == 1) else
                stop_with_failure($sformatf("error: seven_seg_sel = 0x%0h, expected one low bit",
                                            seven_seg_sel));
            assert (!pat[0] && !seven_seg_minus) else
                stop_with_failure("decimal point or minus segment is lit");
            idx = -1;
            for (int n = 0; n < 16; n++)
                if (seg_pkg::seg_digits[n] == pat)
                    idx = n;
            assert (idx >= 0 && idx <= 9) else
                stop_with_failure($sformatf("error: segments = 0x%02h, not a decimal digit", pat));
            for (int p = 0; p < 4; p++) begin
                if (sel[p]) begin
                    d[p]    = idx;
                    seen[p] = 1'b1;
                end
            end
        end
        assert (seen == 4'hf) else
            stop_with_failure("not every digit position was scanned");
        value = d[3] * 1000 + d[2] * 100 + d[1] * 10 + d[0];
    endtask

    initial begin
        int value;
        int last;
        logic seen_clear;
        void'($urandom(10));
        cpu_resetn = 1'b0;
        user_pb    = '1;                    // no button pressed.
        user_dipsw = '0;
        clkin_125  = 1'b0;
        clkin_sma  = 1'b0;
        clkout_sma = 1'b0;
        last       = 0;
        repeat (4) @(posedge clk);
        cpu_resetn <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            seen_clear = 1'b0;
            case (rows[i].act)
                act_run:   press_key(board_pkg::key_run, seen_clear);
                act_clear: press_key(board_pkg::key_clear, seen_clear);
                default:   repeat (rows[i].cycles) @(posedge clk);
            endcase
            @(negedge clk);
            assert (user_led == rows[i].led) else
                stop_with_failure($sformatf("error: user_led = 0x%02h, expected 0x%02h",
                                            user_led, rows[i].led));
            assert (speaker_out == 1'b0) else
                stop_with_failure($sformatf("error: speaker_out = 0x%0h, expected 0x0",
                                            speaker_out));
            assert (seen_clear == rows[i].pulse) else
                stop_with_failure($sformatf("error: user_led[1] pulse = 0x%0h, expected 0x%0h",
                                            seen_clear, rows[i].pulse));
            if (rows[i].chk) begin
                read_display(value);
                if (rows[i].same) begin
                    assert (value == last) else
                        stop_with_failure($sformatf("error: display = 0x%04h, expected 0x%04h",
                                                    to_bcd(value), to_bcd(last)));
                end else begin
                    assert (value >= rows[i].expected - rows[i].tol &&
                            value <= rows[i].expected + rows[i].tol) else
                        stop_with_failure($sformatf("error: display = 0x%04h, expected 0x%04h +/- %0d",
                                                    to_bcd(value), to_bcd(rows[i].expected),
                                                    rows[i].tol));
                end
                last = value;
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // limit grows with the table, plus a margin.
    initial begin
        int limit;
        limit = 200;
        for (int i = 0; i < n_rows; i++)
            limit += rows[i].cycles + press_cycles + scan_cycles + 4;
        #(limit * clk_period);
        stop_with_failure("timeout: the stimulus table did not finish in time");
    end

endmodule

`default_nettype wire

// ==== board_specific_top.f ====
verilog/board_pkg.sv
verilog/seg_pkg.sv
verilog/tick_timer.sv
verilog/bcd_counter.sv
verilog/stopwatch_fsm.sv
verilog/seg_display.sv
verilog/top.sv
verilog/board_specific_top.sv
tb/tb_board_specific_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stopwatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_board_specific_top \
    -f board_specific_top.f \
    -o tb_sim

./obj_dir/tb_sim
